// File: gateway_pkg.sv
package gateway_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  localparam int NODE_ID_W     = 2;
  localparam int SEQ_W         = 6;
  // Link word is {id, seq}
  localparam int LINK_W        = NODE_ID_W + SEQ_W;
  localparam int TAG_PAYLOAD_W = 8;
  // Start bit, client id, payload
  localparam int TAG_FRAME_W   = 1 + NODE_ID_W + TAG_PAYLOAD_W;
  localparam int TAG_CNT_W     = $clog2(TAG_FRAME_W);
  localparam int ROM_ADDR_W    = 4;
  localparam int ROM_DATA_W    = 12;

  // Payload bit positions, count sits in the low SEQ_W bits
  localparam int TAG_RESET_BIT = 7;
  localparam int TAG_EN_BIT    = 6;

  ////////////////////////////////////////////////////////////
  // Opcodes and states
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    TRACE_SEND   = 2'd0,
    TRACE_WAIT   = 2'd1,
    TRACE_FINISH = 2'd2
  } trace_op_e;

  typedef enum logic [1:0] {REPLAY_FETCH, REPLAY_SHIFT, REPLAY_WAIT, REPLAY_DONE} replay_state_e;

  typedef enum logic {TAG_IDLE, TAG_SHIFT} tag_state_e;

  typedef enum logic [1:0] {ARB_IDLE, ARB_SEND, ARB_ACK, ARB_RELEASE} arb_state_e;

  typedef enum logic [1:0] {NODE_IDLE, NODE_REQ, NODE_WAIT_ACK_LOW} node_state_e;

endpackage

// File: tag_trace_rom.sv
`timescale 1ns/1ns

module tag_trace_rom
  (input  logic [gateway_pkg::ROM_ADDR_W-1:0] addr_i,
   output logic [gateway_pkg::ROM_DATA_W-1:0] data_o
  );

  import gateway_pkg::*;

  // Entry is {opcode, id, payload}
  // Per node: assert reset, hold it a few cycles, release with node disabled
  always_comb
  begin
    case (addr_i)
      4'd0:    data_o = {TRACE_SEND,   2'd0, 8'h80};
      4'd1:    data_o = {TRACE_WAIT,   2'd0, 8'd4};
      4'd2:    data_o = {TRACE_SEND,   2'd0, 8'h00};
      4'd3:    data_o = {TRACE_SEND,   2'd1, 8'h80};
      4'd4:    data_o = {TRACE_WAIT,   2'd0, 8'd4};
      4'd5:    data_o = {TRACE_SEND,   2'd1, 8'h00};
      4'd6:    data_o = {TRACE_SEND,   2'd2, 8'h80};
      4'd7:    data_o = {TRACE_WAIT,   2'd0, 8'd4};
      4'd8:    data_o = {TRACE_SEND,   2'd2, 8'h00};
      4'd9:    data_o = {TRACE_SEND,   2'd3, 8'h80};
      4'd10:   data_o = {TRACE_WAIT,   2'd0, 8'd4};
      4'd11:   data_o = {TRACE_SEND,   2'd3, 8'h00};
      // End of trace, unused addresses also finish
      default: data_o = {TRACE_FINISH, 2'd0, 8'h00};
    endcase
  end

endmodule

// File: tag_trace_replay.sv
`timescale 1ns/1ns

module tag_trace_replay
  (input  logic                              clk_i,
   input  logic                              arst_n_i,
   output logic [gateway_pkg::ROM_ADDR_W-1:0] rom_addr_o,
   input  logic [gateway_pkg::ROM_DATA_W-1:0] rom_data_i,
   output logic                              tag_bit_o,
   output logic                              done_o
  );

  import gateway_pkg::*;

  replay_state_e            state_r;
  logic [ROM_ADDR_W-1:0]    addr_r;
  logic [TAG_FRAME_W-1:0]   shift_r;
  logic [TAG_CNT_W-1:0]     bit_cnt_r;
  logic [TAG_PAYLOAD_W-1:0] wait_cnt_r;
  trace_op_e                entry_op;
  logic [NODE_ID_W-1:0]     entry_id;
  logic [TAG_PAYLOAD_W-1:0] entry_payload;

  // Entry fields
  assign entry_op      = trace_op_e'(rom_data_i[ROM_DATA_W-1 -: $bits(trace_op_e)]);
  assign entry_id      = rom_data_i[TAG_PAYLOAD_W +: NODE_ID_W];
  assign entry_payload = rom_data_i[TAG_PAYLOAD_W-1:0];

  assign rom_addr_o = addr_r;
  // Shift register empties to zero, so the line idles low between frames
  assign tag_bit_o  = shift_r[TAG_FRAME_W-1];
  assign done_o     = (state_r == REPLAY_DONE);

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_r    <= REPLAY_FETCH;
      addr_r     <= '0;
      shift_r    <= '0;
      bit_cnt_r  <= '0;
      wait_cnt_r <= '0;
    end
    else
    begin
      case (state_r)
        REPLAY_FETCH:
        begin
          addr_r <= addr_r + 1'b1;
          case (entry_op)
            TRACE_SEND:
            begin
              shift_r   <= {1'b1, entry_id, entry_payload};
              bit_cnt_r <= '0;
              state_r   <= REPLAY_SHIFT;
            end
            TRACE_WAIT:
            begin
              wait_cnt_r <= entry_payload;
              state_r    <= REPLAY_WAIT;
            end
            default: state_r <= REPLAY_DONE;
          endcase
        end
        REPLAY_SHIFT:
        begin
          shift_r <= shift_r << 1;
          if (bit_cnt_r == TAG_CNT_W'(TAG_FRAME_W-1))
            state_r <= REPLAY_FETCH;
          else
            bit_cnt_r <= bit_cnt_r + 1'b1;
        end
        REPLAY_WAIT:
        begin
          if (wait_cnt_r <= 1)
            state_r <= REPLAY_FETCH;
          else
            wait_cnt_r <= wait_cnt_r - 1'b1;
        end
        default: state_r <= REPLAY_DONE;
      endcase
    end
  end

  // Line stays quiet outside a frame
  a_idle_low: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (state_r != REPLAY_SHIFT) |-> !tag_bit_o);

endmodule

// File: tag_master.sv
`timescale 1ns/1ns

module tag_master
  #(parameter int NUM_NODES_P = 4)
  (input  logic                                          clk_i,
   input  logic                                          arst_n_i,
   input  logic                                          replay_bit_i,
   input  logic                                          replay_done_i,
   input  logic                                          tag_ext_bit_i,
   output logic [NUM_NODES_P-1:0]                        cfg_reset_o,
   output logic [NUM_NODES_P-1:0]                        cfg_en_o,
   output logic [NUM_NODES_P-1:0][gateway_pkg::SEQ_W-1:0] cfg_count_o
  );

  import gateway_pkg::*;

  tag_state_e               state_r;
  logic [TAG_CNT_W-1:0]     bit_cnt_r;
  logic [TAG_FRAME_W-3:0]   shift_r;
  logic [TAG_FRAME_W-2:0]   frame;
  logic                     tag_bit;
  logic                     frame_done;
  logic [NODE_ID_W-1:0]     frame_id;
  logic [TAG_PAYLOAD_W-1:0] frame_payload;

  // External pin takes over once the boot trace is finished
  assign tag_bit = replay_done_i ? tag_ext_bit_i : replay_bit_i;

  // Frame body with the current bit shifted in
  assign frame         = {shift_r, tag_bit};
  assign frame_done    = (state_r == TAG_SHIFT) && (bit_cnt_r == TAG_CNT_W'(TAG_FRAME_W-2));
  assign frame_id      = frame[TAG_FRAME_W-2 -: NODE_ID_W];
  assign frame_payload = frame[TAG_PAYLOAD_W-1:0];

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_r   <= TAG_IDLE;
      bit_cnt_r <= '0;
    end
    else if (state_r == TAG_IDLE)
    begin
      bit_cnt_r <= '0;
      if (tag_bit)
        state_r <= TAG_SHIFT;
    end
    else if (frame_done)
      state_r <= TAG_IDLE;
    else
      bit_cnt_r <= bit_cnt_r + 1'b1;
  end

  always_ff @(posedge clk_i)
  begin
    if (state_r == TAG_SHIFT)
      shift_r <= frame[TAG_FRAME_W-3:0];
  end

  ////////////////////////////////////////////////////////////
  // Client registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      cfg_reset_o <= '1;
      cfg_en_o    <= '0;
      cfg_count_o <= '0;
    end
    else
    begin
      // Ids without a node fall through
      for (int i = 0; i < NUM_NODES_P; i++)
      begin
        if (frame_done && frame_id == NODE_ID_W'(i))
        begin
          cfg_reset_o[i] <= frame_payload[TAG_RESET_BIT];
          cfg_en_o[i]    <= frame_payload[TAG_EN_BIT];
          cfg_count_o[i] <= frame_payload[SEQ_W-1:0];
        end
      end
    end
  end

  a_frame_id: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    frame_done |-> (!$isunknown(frame_id) && frame_id < 3'd4));

endmodule

// File: test_node.sv
`timescale 1ns/1ns

module test_node
  #(parameter logic [gateway_pkg::NODE_ID_W-1:0] NODE_ID = '0)
  (input  logic                           clk_i,
   input  logic                           arst_n_i,
   input  logic                           cfg_reset_i,
   input  logic                           cfg_en_i,
   input  logic [gateway_pkg::SEQ_W-1:0]  cfg_count_i,
   output logic                           req_o,
   input  logic                           ack_i,
   output logic [gateway_pkg::LINK_W-1:0] word_o,
   input  logic                           rx_v_i,
   input  logic [gateway_pkg::SEQ_W-1:0]  rx_seq_i,
   output logic [gateway_pkg::SEQ_W-1:0]  sent_o,
   output logic [gateway_pkg::SEQ_W-1:0]  received_o,
   output logic                           error_o
  );

  import gateway_pkg::*;

  node_state_e state_r;

  assign req_o  = (state_r == NODE_REQ);
  // Sequence number is the sent count, constant until ack
  assign word_o = {NODE_ID, sent_o};

  ////////////////////////////////////////////////////////////
  // Four-phase handshake
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      state_r <= NODE_IDLE;
    else
    begin
      case (state_r)
        NODE_IDLE:
        begin
          if (cfg_en_i && !cfg_reset_i && (sent_o < cfg_count_i))
            state_r <= NODE_REQ;
        end
        NODE_REQ:
        begin
          if (ack_i)
            state_r <= NODE_WAIT_ACK_LOW;
        end
        default:
        begin
          if (!ack_i)
            state_r <= NODE_IDLE;
        end
      endcase
    end
  end

  // Counters and sequence check
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      sent_o     <= '0;
      received_o <= '0;
      error_o    <= 1'b0;
    end
    else if (cfg_reset_i)
    begin
      sent_o     <= '0;
      received_o <= '0;
      error_o    <= 1'b0;
    end
    else
    begin
      if (state_r == NODE_REQ && ack_i)
        sent_o <= sent_o + 1'b1;
      if (rx_v_i)
      begin
        // Received count doubles as the expected sequence number
        if (rx_seq_i != received_o)
          error_o <= 1'b1;
        received_o <= received_o + 1'b1;
      end
    end
  end

  a_req_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $fell(req_o) |-> $past(ack_i));

  a_req_rise: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(req_o) |-> !ack_i);

endmodule

// File: link_arbiter.sv
`timescale 1ns/1ns

module link_arbiter
  #(parameter int NUM_NODES_P = 4)
  (input  logic                                           clk_i,
   input  logic                                           arst_n_i,
   input  logic [NUM_NODES_P-1:0]                         req_i,
   input  logic [NUM_NODES_P-1:0][gateway_pkg::LINK_W-1:0] word_i,
   output logic [NUM_NODES_P-1:0]                         ack_o,
   output logic                                           link_v_o,
   output logic [gateway_pkg::LINK_W-1:0]                 link_data_o,
   input  logic                                           link_ready_i,
   input  logic                                           link_v_i,
   input  logic [gateway_pkg::LINK_W-1:0]                 link_data_i,
   output logic [NUM_NODES_P-1:0]                         rx_v_o,
   output logic [gateway_pkg::SEQ_W-1:0]                  rx_seq_o
  );

  import gateway_pkg::*;

  arb_state_e           state_r;
  // Last granted node, also the owner of the current handshake
  logic [NODE_ID_W-1:0] last_r;
  logic [NODE_ID_W-1:0] pick;
  logic                 pick_v;
  logic [NODE_ID_W-1:0] rx_id;

  // Round-robin search starting after the last grant
  always_comb
  begin
    int idx;
    pick   = last_r;
    pick_v = 1'b0;
    for (int k = 1; k <= NUM_NODES_P; k++)
    begin
      idx = (int'(last_r) + k) % NUM_NODES_P;
      if (!pick_v && req_i[idx])
      begin
        pick   = NODE_ID_W'(idx);
        pick_v = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_r <= ARB_IDLE;
      last_r  <= NODE_ID_W'(NUM_NODES_P-1);
    end
    else
    begin
      case (state_r)
        ARB_IDLE:
        begin
          if (pick_v)
          begin
            last_r  <= pick;
            state_r <= ARB_SEND;
          end
        end
        ARB_SEND:    if (link_ready_i) state_r <= ARB_ACK;
        ARB_ACK:     if (!req_i[last_r]) state_r <= ARB_RELEASE;
        default:     state_r <= ARB_IDLE;
      endcase
    end
  end

  // Word captured at grant and held until accepted
  always_ff @(posedge clk_i)
  begin
    if (state_r == ARB_IDLE && pick_v)
      link_data_o <= word_i[pick];
  end

  assign link_v_o = (state_r == ARB_SEND);

  always_comb
  begin
    ack_o = '0;
    if (state_r == ARB_ACK)
      ack_o[last_r] = 1'b1;
  end

  ////////////////////////////////////////////////////////////
  // Inbound steering
  ////////////////////////////////////////////////////////////

  assign rx_id    = link_data_i[LINK_W-1 -: NODE_ID_W];
  assign rx_seq_o = link_data_i[SEQ_W-1:0];

  // Ids with no node get no pulse
  always_comb
  begin
    rx_v_o = '0;
    for (int i = 0; i < NUM_NODES_P; i++)
      if (link_v_i && rx_id == NODE_ID_W'(i))
        rx_v_o[i] = 1'b1;
  end

  a_stall_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (link_v_o && !link_ready_i) |=> (link_v_o && $stable(link_data_o)));

  a_ack_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(ack_o));

endmodule

// File: gateway_top.sv
`timescale 1ns/1ns

module gateway_top
  #(parameter int NUM_NODES_P = 4)
  (input  logic                                          clk_i,
   input  logic                                          arst_n_i,
   input  logic                                          tag_ext_bit_i,
   output logic                                          done_o,
   output logic                                          link_v_o,
   output logic [gateway_pkg::LINK_W-1:0]                link_data_o,
   input  logic                                          link_ready_i,
   input  logic                                          link_v_i,
   input  logic [gateway_pkg::LINK_W-1:0]                link_data_i,
   output logic [NUM_NODES_P-1:0][gateway_pkg::SEQ_W-1:0] sent_o,
   output logic [NUM_NODES_P-1:0][gateway_pkg::SEQ_W-1:0] received_o,
   output logic [NUM_NODES_P-1:0]                        error_o
  );

  import gateway_pkg::*;

  logic [ROM_ADDR_W-1:0]               rom_addr;
  logic [ROM_DATA_W-1:0]               rom_data;
  logic                                replay_bit;
  logic [NUM_NODES_P-1:0]              cfg_reset;
  logic [NUM_NODES_P-1:0]              cfg_en;
  logic [NUM_NODES_P-1:0][SEQ_W-1:0]   cfg_count;
  logic [NUM_NODES_P-1:0]              req;
  logic [NUM_NODES_P-1:0]              ack;
  logic [NUM_NODES_P-1:0][LINK_W-1:0]  word;
  logic [NUM_NODES_P-1:0]              rx_v;
  logic [SEQ_W-1:0]                    rx_seq;

  ////////////////////////////////////////////////////////////
  // Boot path
  ////////////////////////////////////////////////////////////

  tag_trace_rom u_rom
    (.addr_i (rom_addr),
     .data_o (rom_data));

  tag_trace_replay u_replay
    (.clk_i      (clk_i),
     .arst_n_i   (arst_n_i),
     .rom_addr_o (rom_addr),
     .rom_data_i (rom_data),
     .tag_bit_o  (replay_bit),
     .done_o     (done_o));

  tag_master #(.NUM_NODES_P(NUM_NODES_P)) u_tag_master
    (.clk_i         (clk_i),
     .arst_n_i      (arst_n_i),
     .replay_bit_i  (replay_bit),
     .replay_done_i (done_o),
     .tag_ext_bit_i (tag_ext_bit_i),
     .cfg_reset_o   (cfg_reset),
     .cfg_en_o      (cfg_en),
     .cfg_count_o   (cfg_count));

  ////////////////////////////////////////////////////////////
  // Traffic path
  ////////////////////////////////////////////////////////////

  link_arbiter #(.NUM_NODES_P(NUM_NODES_P)) u_arbiter
    (.clk_i        (clk_i),
     .arst_n_i     (arst_n_i),
     .req_i        (req),
     .word_i       (word),
     .ack_o        (ack),
     .link_v_o     (link_v_o),
     .link_data_o  (link_data_o),
     .link_ready_i (link_ready_i),
     .link_v_i     (link_v_i),
     .link_data_i  (link_data_i),
     .rx_v_o       (rx_v),
     .rx_seq_o     (rx_seq));

  for (genvar n = 0; n < NUM_NODES_P; n++)
  begin : g_node
    test_node #(.NODE_ID(NODE_ID_W'(n))) u_node
      (.clk_i       (clk_i),
       .arst_n_i    (arst_n_i),
       .cfg_reset_i (cfg_reset[n]),
       .cfg_en_i    (cfg_en[n]),
       .cfg_count_i (cfg_count[n]),
       .req_o       (req[n]),
       .ack_i       (ack[n]),
       .word_o      (word[n]),
       .rx_v_i      (rx_v[n]),
       .rx_seq_i    (rx_seq),
       .sent_o      (sent_o[n]),
       .received_o  (received_o[n]),
       .error_o     (error_o[n]));
  end

endmodule

// File: tb_gateway.sv
`timescale 1ns/1ns

module tb_gateway;

  import gateway_pkg::*;

  localparam int NUM_NODES = 4;
  // Boot is about 120 cycles and the 13 tag frames and 26 words that follow
  // take well under 1000 cycles even under back-pressure
  localparam int RUN_LIMIT = 5000;

  logic                                clk_i         = 1'b0;
  logic                                arst_n_i      = 1'b0;
  logic                                tag_ext_bit_i = 1'b0;
  logic                                link_ready_i  = 1'b1;
  logic                                link_v_i      = 1'b0;
  logic [LINK_W-1:0]                   link_data_i   = '0;
  logic                                done_o;
  logic                                link_v_o;
  logic [LINK_W-1:0]                   link_data_o;
  logic [NUM_NODES-1:0][SEQ_W-1:0]     sent_o;
  logic [NUM_NODES-1:0][SEQ_W-1:0]     received_o;
  logic [NUM_NODES-1:0]                error_o;

  int          errors       = 0;
  int          tests_failed = 0;
  int          run_cycles   = 0;
  int          neg_cycle    = 0;
  int          seed         = 72;
  bit          random_ready = 1'b0;
  bit          stall_seen   = 1'b0;
  logic [LINK_W-1:0] stall_data;
  // Loopback corruption target
  bit          corrupt_armed = 1'b0;
  int          corrupt_id;
  int          corrupt_seq;
  int          exp_seq [NUM_NODES];
  int          out_cnt [NUM_NODES];
  logic [LINK_W-1:0] ret_q [$];
  int          due_q [$];

  gateway_top #(.NUM_NODES_P(NUM_NODES)) UUT
    (.clk_i         (clk_i),
     .arst_n_i      (arst_n_i),
     .tag_ext_bit_i (tag_ext_bit_i),
     .done_o        (done_o),
     .link_v_o      (link_v_o),
     .link_data_o   (link_data_o),
     .link_ready_i  (link_ready_i),
     .link_v_i      (link_v_i),
     .link_data_i   (link_data_i),
     .sent_o        (sent_o),
     .received_o    (received_o),
     .error_o       (error_o));

  always #2 clk_i = ~clk_i;

  task automatic check(input bit cond, input string msg);
    assert (cond)
    else
    begin
      $display("CHECK FAILED at %0t ns: %s", $time, msg);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Link model with back-pressure, outbound checks and loopback
  ////////////////////////////////////////////////////////////

  always @(negedge clk_i)
  begin : link_model
    logic [LINK_W-1:0] word;
    int id;
    int seq;
    neg_cycle++;
    if (stall_seen)
      check(link_v_o && link_data_o == stall_data, "link word changed while stalled");
    if (random_ready)
      link_ready_i = ($random(seed) % 4) != 0;
    else
      link_ready_i = 1'b1;
    stall_seen = link_v_o && !link_ready_i;
    stall_data = link_data_o;
    // Transfer takes place on the coming rising edge
    if (link_v_o && link_ready_i)
    begin
      id  = int'(link_data_o[LINK_W-1 -: NODE_ID_W]);
      seq = int'(link_data_o[SEQ_W-1:0]);
      check(seq == exp_seq[id],
            $sformatf("node %0d sent seq %0d, expected %0d", id, seq, exp_seq[id]));
      exp_seq[id]++;
      out_cnt[id]++;
      ret_q.push_back(link_data_o);
      due_q.push_back(neg_cycle + 3);
    end
    link_v_i    = 1'b0;
    link_data_i = '0;
    if (due_q.size() > 0 && due_q[0] <= neg_cycle)
    begin
      word = ret_q.pop_front();
      void'(due_q.pop_front());
      if (corrupt_armed && int'(word[LINK_W-1 -: NODE_ID_W]) == corrupt_id &&
          int'(word[SEQ_W-1:0]) == corrupt_seq)
      begin
        word          = word ^ LINK_W'(8);
        corrupt_armed = 1'b0;
      end
      link_v_i    = 1'b1;
      link_data_i = word;
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Frame goes out MSB first with the start bit leading
  task automatic send_tag(input logic [NODE_ID_W-1:0] id, input logic [TAG_PAYLOAD_W-1:0] pl);
    logic [TAG_FRAME_W-1:0] frame;
    frame = {1'b1, id, pl};
    for (int i = TAG_FRAME_W - 1; i >= 0; i--)
    begin
      @(negedge clk_i);
      tag_ext_bit_i = frame[i];
    end
    @(negedge clk_i);
    tag_ext_bit_i = 1'b0;
    repeat (2) @(negedge clk_i);
  endtask

  task automatic reset_node(input int n);
    send_tag(NODE_ID_W'(n), 8'h80);
    exp_seq[n] = 0;
    out_cnt[n] = 0;
  endtask

  task automatic wait_counts(input int n, input int cnt, input int limit);
    int waited;
    waited = 0;
    while ((int'(sent_o[n]) != cnt || int'(received_o[n]) != cnt) && waited < limit)
    begin
      @(negedge clk_i);
      waited++;
    end
    if (int'(sent_o[n]) != cnt || int'(received_o[n]) != cnt)
    begin
      $display("ERROR: node %0d did not reach %0d sent and received within %0d cycles",
               n, cnt, limit);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int start_errors);
    if (errors == start_errors)
      $display("%s: ok", name);
    else
    begin
      $display("%s: %0d errors", name, errors - start_errors);
      tests_failed++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic test_boot;
    int start_errors;
    int waited;
    start_errors = errors;
    waited       = 0;
    while (!done_o && waited < 200)
    begin
      @(negedge clk_i);
      check(!link_v_o, "link_v_o high during boot");
      waited++;
    end
    if (!done_o)
    begin
      $display("ERROR: done_o did not rise within 200 cycles");
      errors++;
    end
    check(sent_o == '0, "sent counts not zero after boot");
    check(received_o == '0, "received counts not zero after boot");
    check(error_o == '0, "error flags set after boot");
    report_test("boot", start_errors);
  endtask

  task automatic test_single_node;
    int start_errors;
    start_errors = errors;
    send_tag(2'd1, 8'h45);
    wait_counts(1, 5, 200);
    repeat (4) @(negedge clk_i);
    check(out_cnt[1] == 5, $sformatf("node 1 put %0d words on the link", out_cnt[1]));
    check(out_cnt[0] + out_cnt[2] + out_cnt[3] == 0, "words from a disabled node");
    check(sent_o[1] == 6'd5 && received_o[1] == 6'd5, "node 1 counts not 5");
    check(error_o == '0, "error flag set with clean loopback");
    report_test("single_node", start_errors);
  endtask

  task automatic test_shared_link;
    int start_errors;
    start_errors = errors;
    random_ready = 1'b1;
    for (int n = 0; n < NUM_NODES; n++)
    begin
      reset_node(n);
      send_tag(NODE_ID_W'(n), {2'b01, SEQ_W'(n + 3)});
    end
    for (int n = 0; n < NUM_NODES; n++)
      wait_counts(n, n + 3, 800);
    repeat (4) @(negedge clk_i);
    random_ready = 1'b0;
    for (int n = 0; n < NUM_NODES; n++)
    begin
      check(out_cnt[n] == n + 3,
            $sformatf("node %0d put %0d words on the link, expected %0d", n, out_cnt[n], n + 3));
      check(int'(sent_o[n]) == n + 3 && int'(received_o[n]) == n + 3,
            $sformatf("node %0d final counts wrong", n));
    end
    check(error_o == '0, "error flag set on shared link");
    report_test("shared_link", start_errors);
  endtask

  task automatic test_error_detect;
    int start_errors;
    start_errors = errors;
    reset_node(2);
    corrupt_id    = 2;
    corrupt_seq   = 1;
    corrupt_armed = 1'b1;
    send_tag(2'd2, 8'h43);
    wait_counts(2, 3, 200);
    repeat (4) @(negedge clk_i);
    check(error_o == 4'b0100, $sformatf("error flags %b, expected 0100", error_o));
    report_test("error_detect", start_errors);
  endtask

  task automatic test_tag_reset;
    int start_errors;
    start_errors = errors;
    reset_node(2);
    send_tag(2'd2, 8'h00);
    check(sent_o[2] == '0 && received_o[2] == '0 && !error_o[2], "node 2 not cleared");
    // Other nodes still hold their shared link totals
    for (int n = 0; n < NUM_NODES; n++)
    begin
      if (n != 2)
        check(int'(sent_o[n]) == n + 3 && int'(received_o[n]) == n + 3 && !error_o[n],
              $sformatf("node %0d changed on node 2 reset", n));
    end
    report_test("tag_reset", start_errors);
  endtask

  // Run limit
  initial
  begin
    while (run_cycles < RUN_LIMIT)
    begin
      @(posedge clk_i);
      run_cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", RUN_LIMIT);
    $display("FAIL: see errors above");
    $finish;
  end

  initial
  begin
    for (int n = 0; n < NUM_NODES; n++)
    begin
      exp_seq[n] = 0;
      out_cnt[n] = 0;
    end
    repeat (10) @(negedge clk_i);
    arst_n_i = 1'b1;
    test_boot();
    test_single_node();
    test_shared_link();
    test_error_detect();
    test_tag_reset();
    $display("Summary: 5 tests, %0d failed, %0d errors", tests_failed, errors);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

// File: filelist.f
gateway_pkg.sv
tag_trace_rom.sv
tag_trace_replay.sv
tag_master.sv
test_node.sv
link_arbiter.sv
gateway_top.sv
tb_gateway.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_gateway -f filelist.f -o sim_gateway

out="$(./obj_dir/sim_gateway)"
echo "$out"

if echo "$out" | grep -qx "PASS: all tests"; then
  exit 0
fi
exit 1
